//--- all.f
+incdir+.
power_pkg.sv
power_apb_decode.sv
power_execute.sv
power_result.sv
power_top.sv
power_assertions.sv
power_tb.sv

//--- power_apb_decode.sv
`include "power_settings.svh"

module power_apb_decode (
    input  logic                     clk,
    input  logic                     rst,

    // APB slave
    input  logic [`POWER_ADDR_W-1:0] paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,

    // Queue state
    input  logic                     full,
    input  logic                     empty,
    input  power_pkg::count_t        count,
    input  power_pkg::result_t       head_result,
    input  power_pkg::operand_t      head_operand,
    input  power_pkg::exponent_t     head_exponent,

    // Launch and queue control
    output logic                     cmd_valid,
    output power_pkg::operand_t      cmd_operand,
    output power_pkg::exponent_t     cmd_exponent,
    output logic                     reserve,
    output logic                     pop
);

    import power_pkg::*;

    logic        access;
    operand_t    wr_operand;
    exponent_t   wr_exponent;
    logic        exp_ok;
    logic        cmd_accept;
    logic        wr_error;
    logic        rd_error;
    logic [31:0] rd_data;

    // ------------------------------------------------------------
    // Access phase and command fields
    // ------------------------------------------------------------

    // Zero wait states, every transfer ends in its access phase
    assign pready = 1'b1;
    assign access = psel & penable;

    assign wr_operand  = pwdata[`POWER_OPERAND_W-1:0];
    assign wr_exponent = pwdata[`POWER_OPERAND_W +: $bits(exponent_t)];
    assign exp_ok      = (wr_exponent <= exponent_t'(`POWER_MAX_EXP));

    assign cmd_accept = access & pwrite & (paddr == REG_CMD) & exp_ok & ~full;

    // ------------------------------------------------------------
    // Register decode
    // ------------------------------------------------------------

    always_comb begin
        // Anything not listed below is an error
        wr_error = 1'b1;
        rd_error = 1'b1;
        rd_data  = '0;
        case (paddr)
            REG_CMD: begin
                wr_error = ~exp_ok | full;
            end
            REG_STATUS: begin
                rd_error = 1'b0;
                rd_data  = 32'({full, count});
            end
            REG_RESULT_LO: begin
                rd_error = empty;
                rd_data  = head_result[31:0];
            end
            REG_RESULT_HI: begin
                rd_error = empty;
                // Upper result byte, then the tags
                rd_data  = 32'({head_exponent, head_operand,
                                head_result[`POWER_RESULT_W-1:32]});
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    assign pslverr = access & (pwrite ? wr_error : rd_error);

    // Zero on writes and on any failed read
    assign prdata = (access & ~pwrite & ~rd_error) ? rd_data : '0;

    // Head leaves the queue on the high word read
    assign pop = access & ~pwrite & (paddr == REG_RESULT_HI) & ~empty;

    // ------------------------------------------------------------
    // Launch register
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= cmd_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            cmd_operand  <= wr_operand;
            cmd_exponent <= wr_exponent;
        end
    end

    // Slot is booked in the same cycle the pipeline sees the command
    assign reserve = cmd_valid;

endmodule

//--- power_assertions.sv
module power_assertions #(
    parameter bit APB_CHECKS  = 1'b0,
    parameter bit PIPE_CHECKS = 1'b0
) (
    input logic clk,
    input logic rst,
    input logic pready,
    input logic full,
    input logic cmd_valid,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------
    // APB side
    // ------------------------------------------------------------

    if (APB_CHECKS) begin : apb_rules
        // Zero wait states
        pready_high: assert property (@(posedge clk) disable iff (rst) pready)
            else $error("pready is low");

        no_launch_when_full: assert property (
            @(posedge clk) disable iff (rst) cmd_valid |-> !full)
            else $error("command launched while the queue is full");
    end

    // ------------------------------------------------------------
    // Pipeline latency, four stage registers
    // ------------------------------------------------------------

    if (PIPE_CHECKS) begin : pipe_rules
        result_arrives: assert property (
            @(posedge clk) disable iff (rst) cmd_valid |-> ##4 out_valid)
            else $error("out_valid missing four cycles after cmd_valid");

        no_stray_result: assert property (
            @(posedge clk) disable iff (rst) !cmd_valid |-> ##4 !out_valid)
            else $error("out_valid without a command four cycles earlier");
    end

endmodule

bind power_apb_decode power_assertions #(
    .APB_CHECKS  (1'b1),
    .PIPE_CHECKS (1'b0)
) apb_rules_i (
    .clk       (clk),
    .rst       (rst),
    .pready    (pready),
    .full      (full),
    .cmd_valid (cmd_valid),
    .out_valid (1'b0)
);

bind power_execute power_assertions #(
    .APB_CHECKS  (1'b0),
    .PIPE_CHECKS (1'b1)
) pipe_rules_i (
    .clk       (clk),
    .rst       (rst),
    .pready    (1'b1),
    .full      (1'b0),
    .cmd_valid (cmd_valid),
    .out_valid (out_valid)
);

//--- power_execute.sv
`include "power_settings.svh"

module power_execute (
    input  logic                 clk,
    input  logic                 rst,

    // Command from the launch register
    input  logic                 cmd_valid,
    input  power_pkg::operand_t  cmd_operand,
    input  power_pkg::exponent_t cmd_exponent,

    // Finished power with its tags
    output logic                 out_valid,
    output power_pkg::result_t   out_result,
    output power_pkg::operand_t  out_operand,
    output power_pkg::exponent_t out_exponent
);

    import power_pkg::*;

    localparam int STAGES = `POWER_STAGES;

    // Inputs seen by each stage, index 0 is the seed
    logic      src_valid [0:STAGES-1];
    operand_t  src_op    [0:STAGES-1];
    exponent_t src_exp   [0:STAGES-1];
    result_t   src_pow   [0:STAGES-1];

    // Stage registers
    logic      stage_valid [1:STAGES];
    operand_t  stage_op    [1:STAGES];
    exponent_t stage_exp   [1:STAGES];
    result_t   stage_pow   [1:STAGES];

    result_t   next_pow    [1:STAGES];

    // ------------------------------------------------------------
    // Seed and stage inputs
    // ------------------------------------------------------------

    always_comb begin
        src_valid[0] = cmd_valid;
        src_op[0]    = cmd_operand;
        src_exp[0]   = cmd_exponent;
        // x^0 is 1, otherwise start from x itself
        src_pow[0]   = (cmd_exponent == '0) ? result_t'(1) : result_t'(cmd_operand);
        for (int k = 1; k < STAGES; k++) begin
            src_valid[k] = stage_valid[k];
            src_op[k]    = stage_op[k];
            src_exp[k]   = stage_exp[k];
            src_pow[k]   = stage_pow[k];
        end
    end

    // Stage k multiplies only while k is below the exponent
    always_comb begin
        for (int k = 1; k <= STAGES; k++) begin
            if (src_exp[k-1] > exponent_t'(k)) begin
                next_pow[k] = result_t'(src_pow[k-1] * result_t'(src_op[k-1]));
            end else begin
                next_pow[k] = src_pow[k-1];
            end
        end
    end

    // ------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 1; k <= STAGES; k++) begin
                stage_valid[k] <= 1'b0;
            end
        end else begin
            for (int k = 1; k <= STAGES; k++) begin
                stage_valid[k] <= src_valid[k-1];
            end
        end
    end

    // Payload follows its valid bit, no stall
    always_ff @(posedge clk) begin
        for (int k = 1; k <= STAGES; k++) begin
            stage_op[k]  <= src_op[k-1];
            stage_exp[k] <= src_exp[k-1];
            stage_pow[k] <= next_pow[k];
        end
    end

    assign out_valid    = stage_valid[STAGES];
    assign out_result   = stage_pow[STAGES];
    assign out_operand  = stage_op[STAGES];
    assign out_exponent = stage_exp[STAGES];

endmodule

//--- power_patterns.txt
# name kind a b c, all hex. pow/res/peek: a operand, b exponent, c power. cmd: c pslverr
# sts: a occupancy, b full flag. err: a address, b 1 for a write
pow_0_0 pow 00 0 1
pow_0_1 pow 00 1 0
pow_0_2 pow 00 2 0
pow_0_3 pow 00 3 0
pow_0_4 pow 00 4 0
pow_0_5 pow 00 5 0
pow_1_0 pow 01 0 1
pow_1_1 pow 01 1 1
pow_1_2 pow 01 2 1
pow_1_3 pow 01 3 1
pow_1_4 pow 01 4 1
pow_1_5 pow 01 5 1
pow_3_0 pow 03 0 1
pow_3_1 pow 03 1 3
pow_3_2 pow 03 2 9
pow_3_3 pow 03 3 1b
pow_3_4 pow 03 4 51
pow_3_5 pow 03 5 f3
pow_255_0 pow ff 0 1
pow_255_1 pow ff 1 ff
pow_255_2 pow ff 2 fe01
pow_255_3 pow ff 3 fd02ff
pow_255_4 pow ff 4 fc05fc01
pow_255_5 pow ff 5 fb09f604ff
fill_a cmd 02 3 0
fill_b cmd 05 2 0
fill_c cmd 07 4 0
fill_d cmd 0a 5 0
fill_status sts 4 1 0
over_full cmd 04 2 1
still_full sts 4 1 0
drain_a res 02 3 8
after_pop sts 3 0 0
refill cmd 04 2 0
refill_status sts 4 1 0
drain_b res 05 2 19
bad_exp_6 cmd 01 6 1
bad_exp_7 cmd 01 7 1
exp_status sts 3 0 0
drain_c res 07 4 961
drain_d res 0a 5 186a0
drain_e res 04 2 10
drained sts 0 0 0
empty_lo err 8 0 0
empty_hi err c 0 0
unmapped_rd err 2 0 0
unmapped_wr err 6 1 0
cmd_read err 0 0 0
status_write err 4 1 0
peek_cmd cmd 03 5 0
peek_wait sts 1 0 0
peek_1 peek 03 5 f3
peek_2 peek 03 5 f3
peek_hold sts 1 0 0
peek_pop res 03 5 f3
peek_done sts 0 0 0

//--- power_pkg.sv
`include "power_settings.svh"

package power_pkg;

    // ------------------------------------------------------------
    // Datapath words
    // ------------------------------------------------------------

    typedef logic [`POWER_OPERAND_W-1:0] operand_t;

    // Only 0 to 5 are accepted by the decoder
    typedef logic [2:0] exponent_t;

    typedef logic [`POWER_RESULT_W-1:0] result_t;

    // Needs to hold the full depth, not just depth - 1
    typedef logic [$clog2(`POWER_QUEUE_DEPTH + 1)-1:0] count_t;

    // ------------------------------------------------------------
    // Register offsets
    // ------------------------------------------------------------

    typedef enum logic [`POWER_ADDR_W-1:0] {
        REG_CMD       = 'h0,
        REG_STATUS    = 'h4,
        REG_RESULT_LO = 'h8,
        REG_RESULT_HI = 'hC
    } reg_addr_e;

endpackage

//--- power_result.sv
`include "power_settings.svh"

module power_result (
    input  logic                 clk,
    input  logic                 rst,

    // From the decoder
    input  logic                 reserve,
    input  logic                 pop,

    // From the pipeline
    input  logic                 out_valid,
    input  power_pkg::result_t   out_result,
    input  power_pkg::operand_t  out_operand,
    input  power_pkg::exponent_t out_exponent,

    // Head entry and state
    output power_pkg::result_t   head_result,
    output power_pkg::operand_t  head_operand,
    output power_pkg::exponent_t head_exponent,
    output logic                 empty,
    output logic                 full,
    output power_pkg::count_t    count
);

    import power_pkg::*;

    localparam int DEPTH = `POWER_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    result_t    mem_result   [DEPTH];
    operand_t   mem_operand  [DEPTH];
    exponent_t  mem_exponent [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Slots in use or promised to commands still in flight
    count_t booked;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------
    // Pointers and counters
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (out_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
        end
    end

    // Completed entries only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({out_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            booked <= '0;
        end else begin
            case ({reserve, pop})
                2'b10:   booked <= booked + 1'b1;
                2'b01:   booked <= booked - 1'b1;
                default: booked <= booked;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (out_valid) begin
            mem_result[wr_ptr]   <= out_result;
            mem_operand[wr_ptr]  <= out_operand;
            mem_exponent[wr_ptr] <= out_exponent;
        end
    end

    assign head_result   = mem_result[rd_ptr];
    assign head_operand  = mem_operand[rd_ptr];
    assign head_exponent = mem_exponent[rd_ptr];

    assign empty = (count == '0);
    assign full  = (booked >= count_t'(DEPTH));

endmodule

//--- power_settings.svh
`ifndef POWER_SETTINGS_SVH
`define POWER_SETTINGS_SVH

// ------------------------------------------------------------
// Datapath sizing
// ------------------------------------------------------------

`define POWER_OPERAND_W   8
`define POWER_MAX_EXP     5

// Enough bits to hold the largest operand to the largest power
`define POWER_RESULT_W    (`POWER_OPERAND_W * `POWER_MAX_EXP)

// Multiply stages after the seed
`define POWER_STAGES      4

// ------------------------------------------------------------
// Queue and bus
// ------------------------------------------------------------

`define POWER_QUEUE_DEPTH 4
`define POWER_ADDR_W      4

`endif

//--- power_tb.sv
`include "power_settings.svh"

module power_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import power_pkg::*;

    localparam int HALF       = 4;
    localparam int POLL_LIMIT = 8;

    logic                     clk;
    logic                     rst;
    logic [`POWER_ADDR_W-1:0] paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;

    // One entry per pattern line
    string       t_name [$];
    string       t_kind [$];
    logic [63:0] t_a [$];
    logic [63:0] t_b [$];
    logic [63:0] t_c [$];

    // Name of the test whose transfers are on the bus
    string current_test;

    int errors;
    int tests_failed;

    power_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #HALF clk = ~clk;

    // ------------------------------------------------------------
    // Expected values
    // ------------------------------------------------------------

    // Repeated multiplication, x^0 is 1
    function automatic result_t compute_power(input operand_t op, input exponent_t e);
        result_t acc;
        acc = result_t'(1);
        for (int i = 0; i < int'(e); i++) begin
            acc = result_t'(acc * result_t'(op));
        end
        return acc;
    endfunction

    task automatic check_result(input string name, input result_t exp_res,
                                input operand_t exp_op, input exponent_t exp_exp,
                                input result_t got_res, input operand_t got_op,
                                input exponent_t got_exp);
        if (got_res !== exp_res) begin
            $display("Error: %s result expected %h actual %h", name, exp_res, got_res);
            errors++;
        end
        if (got_op !== exp_op) begin
            $display("Error: %s operand tag expected %h actual %h", name, exp_op, got_op);
            errors++;
        end
        if (got_exp !== exp_exp) begin
            $display("Error: %s exponent tag expected %0d actual %0d", name, exp_exp, got_exp);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input count_t exp_count, input logic exp_full,
                                input count_t got_count, input logic got_full);
        if (got_count !== exp_count || got_full !== exp_full) begin
            $display("Error: %s status expected count %0d full %b actual count %0d full %b",
                     name, exp_count, exp_full, got_count, got_full);
            errors++;
        end
    endtask

    task automatic check_error(input string name, input logic exp_err, input logic got_err);
        if (got_err !== exp_err) begin
            $display("Error: %s pslverr expected %b actual %b", name, exp_err, got_err);
            errors++;
        end
    endtask

    task automatic check_ready(input string name, input logic got_ready);
        if (got_ready !== 1'b1) begin
            $display("Error: %s pready expected 1 actual %b", name, got_ready);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [31:0] exp_word, input logic [31:0] got_word);
        if (got_word !== exp_word) begin
            $display("Error: %s %s expected %h actual %h", name, what, exp_word, got_word);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // APB access
    // ------------------------------------------------------------

    task automatic apb_access(input logic [`POWER_ADDR_W-1:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // Sample just ahead of the closing edge
        #(HALF - 1);
        rdata = prdata;
        err   = pslverr;
        check_ready(current_test, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        repeat ($urandom % 3) @(negedge clk);
    endtask

    task automatic read_status(output count_t cnt, output logic fl, output logic err);
        logic [31:0] data;
        apb_access(REG_STATUS, 1'b0, 32'h0, data, err);
        cnt = data[2:0];
        fl  = data[3];
    endtask

    // Poll until the occupancy reaches the target or the poll limit runs out
    task automatic wait_count(input count_t target, output count_t cnt, output logic fl,
                              output logic err);
        logic poll_err;
        int   polls;
        polls = 0;
        read_status(cnt, fl, err);
        while (cnt != target && polls < POLL_LIMIT) begin
            read_status(cnt, fl, poll_err);
            err = err | poll_err;
            polls++;
        end
    endtask

    task automatic read_result(output result_t res, output operand_t op, output exponent_t e,
                               output logic err_lo, output logic err_hi);
        logic [31:0] lo;
        logic [31:0] hi;
        apb_access(REG_RESULT_LO, 1'b0, 32'h0, lo, err_lo);
        apb_access(REG_RESULT_HI, 1'b0, 32'h0, hi, err_hi);
        res = {hi[7:0], lo};
        op  = hi[15:8];
        e   = hi[18:16];
    endtask

    // ------------------------------------------------------------
    // Pattern file
    // ------------------------------------------------------------

    task automatic load_patterns();
        int          fd;
        string       line;
        string       name;
        string       kind;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        fd = $fopen("power_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open power_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %s %h %h %h", name, kind, a, b, c) == 5) begin
                        t_name.push_back(name);
                        t_kind.push_back(kind);
                        t_a.push_back(a);
                        t_b.push_back(b);
                        t_c.push_back(c);
                    end else begin
                        $display("Pattern line could not be parsed: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int idx);
        string       name;
        string       kind;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        result_t     want;
        result_t     got_res;
        operand_t    got_op;
        exponent_t   got_exp;
        count_t      cnt;
        logic        fl;
        logic        err;
        logic        err_hi;
        logic [31:0] data;
        int          errors_before;
        name = t_name[idx];
        kind = t_kind[idx];
        a    = t_a[idx];
        b    = t_b[idx];
        c    = t_c[idx];
        current_test  = name;
        errors_before = errors;
        want = compute_power(operand_t'(a), exponent_t'(b));
        if ((kind == "pow" || kind == "res" || kind == "peek") && result_t'(c) !== want) begin
            $display("%s: pattern file power %h disagrees with the exponent rule", name, c);
            errors++;
        end
        case (kind)
            "pow": begin
                apb_access(REG_CMD, 1'b1, 32'({b[2:0], a[7:0]}), data, err);
                check_error(name, 1'b0, err);
                wait_count(count_t'(1), cnt, fl, err);
                check_error(name, 1'b0, err);
                read_result(got_res, got_op, got_exp, err, err_hi);
                check_error(name, 1'b0, err);
                check_error(name, 1'b0, err_hi);
                check_result(name, want, operand_t'(a), exponent_t'(b),
                             got_res, got_op, got_exp);
            end
            "res": begin
                read_result(got_res, got_op, got_exp, err, err_hi);
                check_error(name, 1'b0, err);
                check_error(name, 1'b0, err_hi);
                check_result(name, want, operand_t'(a), exponent_t'(b),
                             got_res, got_op, got_exp);
            end
            "cmd": begin
                apb_access(REG_CMD, 1'b1, 32'({b[2:0], a[7:0]}), data, err);
                check_error(name, c[0], err);
                check_word(name, "write prdata", 32'h0, data);
            end
            "sts": begin
                wait_count(count_t'(a), cnt, fl, err);
                check_error(name, 1'b0, err);
                check_status(name, count_t'(a), b[0], cnt, fl);
            end
            "peek": begin
                apb_access(REG_RESULT_LO, 1'b0, 32'h0, data, err);
                check_error(name, 1'b0, err);
                check_word(name, "low word", want[31:0], data);
            end
            "err": begin
                apb_access(a[3:0], b[0], 32'h0, data, err);
                check_error(name, 1'b1, err);
                check_word(name, "prdata", 32'h0, data);
            end
            default: begin
                $display("%s: unknown test kind %s in pattern file", name, kind);
                errors++;
            end
        endcase
        if (errors == errors_before) begin
            $display("%s ok", name);
        end else begin
            $display("%s mismatch", name);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        errors       = 0;
        tests_failed = 0;
        current_test = "";
        void'($urandom(26426));
        load_patterns();
        if (t_name.size() == 0) begin
            $display("No tests found in power_patterns.txt");
            errors++;
        end
        // Budget of 20 clock periods per test
        fork
            begin
                #((t_name.size() + 1) * 20 * 2 * HALF);
                $display("Watchdog expired before all tests finished");
                $display("test failed");
                $finish;
            end
        join_none
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (t_name[i]) begin
            run_test(i);
        end
        $display("%0d tests run, %0d tests failed, %0d errors",
                 t_name.size(), tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- power_top.sv
`include "power_settings.svh"

module power_top (
    input  logic                     clk,
    input  logic                     rst,

    // APB slave
    input  logic [`POWER_ADDR_W-1:0] paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr
);

    import power_pkg::*;

    // Decode to pipeline
    logic      cmd_valid;
    operand_t  cmd_operand;
    exponent_t cmd_exponent;

    // Decode to queue
    logic      reserve;
    logic      pop;

    // Pipeline to queue
    logic      out_valid;
    result_t   out_result;
    operand_t  out_operand;
    exponent_t out_exponent;

    // Queue back to decode
    result_t   head_result;
    operand_t  head_operand;
    exponent_t head_exponent;
    logic      empty;
    logic      full;
    count_t    count;

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------

    power_apb_decode decode_i (
        .clk           (clk),
        .rst           (rst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .full          (full),
        .empty         (empty),
        .count         (count),
        .head_result   (head_result),
        .head_operand  (head_operand),
        .head_exponent (head_exponent),
        .cmd_valid     (cmd_valid),
        .cmd_operand   (cmd_operand),
        .cmd_exponent  (cmd_exponent),
        .reserve       (reserve),
        .pop           (pop)
    );

    power_execute execute_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_operand  (cmd_operand),
        .cmd_exponent (cmd_exponent),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_operand  (out_operand),
        .out_exponent (out_exponent)
    );

    power_result result_i (
        .clk           (clk),
        .rst           (rst),
        .reserve       (reserve),
        .pop           (pop),
        .out_valid     (out_valid),
        .out_result    (out_result),
        .out_operand   (out_operand),
        .out_exponent  (out_exponent),
        .head_result   (head_result),
        .head_operand  (head_operand),
        .head_exponent (head_exponent),
        .empty         (empty),
        .full          (full),
        .count         (count)
    );

endmodule
